//--- gcu.f
gcu_pkg.sv
gcu_bus_fsm.sv
gcu_ram_ptr.sv
gcu_scroll_regs.sv
gcu_vram.sv
gcu_video_timing.sv
gcu_top.sv
tb_gcu.sv

//--- run_sim.sh
#!/bin/sh
# compile with Verilator, run, and pass only when the pass line shows up
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_gcu -f gcu.f &&
{ sim_out="$(./obj_dir/Vtb_gcu)" || true; } &&
printf '%s\n' "$sim_out" &&
printf '%s\n' "$sim_out" | grep -qx 'ALL CHECKS PASSED' ||
{ echo "build or simulation did not pass" >&2; exit 1; }

//--- tb_gcu.sv
// self-checking testbench that drives the tilemap controller CPU side and is built from the file list
`timescale 1ns/1ps

module tb_gcu import gcu_pkg::*; ();

    // op numbers follow the op level order from select down to read low
    localparam int OP_SEL  = 0;
    localparam int OP_WREG = 1;
    localparam int OP_PTR  = 2;
    localparam int OP_WRAM = 3;
    localparam int OP_RDH  = 4;
    localparam int OP_RDL  = 5;
    localparam int ACK_TIMEOUT = 16;

    logic                 CLK96;
    logic                 RESET96;
    logic [DATA_W-1:0]    din, dout;
    logic                 op_select_reg, op_write_reg, op_set_ram_ptr;
    logic                 op_write_ram, op_read_ram_h, op_read_ram_l;
    logic                 ack, flip_x_in, flip_y_in;
    logic [DATA_W-1:0]    bg_scroll_x, bg_scroll_y, fg_scroll_x, fg_scroll_y;
    logic [DATA_W-1:0]    tx_scroll_x, tx_scroll_y, sp_scroll_x, sp_scroll_y;
    logic [3:0]           flip_x, flip_y;
    logic [COORD_W-1:0]   h, v, hs_start, hs_end, vs_start, vs_end;
    logic                 hsync, vsync, fblank, vint;
    logic [LAYER_AW-1:0]  scr0_addr, scr1_addr, scr2_addr;
    logic [SPRITE_AW-1:0] spr_addr;
    logic [DATA_W-1:0]    scr0_data, scr1_data, scr2_data, spr_data;
    logic [8*DATA_W-1:0]  scroll_bus;
    logic [4*DATA_W-1:0]  copy_bus;
    logic [DATA_W-1:0]    model_scroll [8];
    logic [3:0]           model_flip_x, model_flip_y;
    int                   checks, errors, timeouts;

    // scroll outputs by register index and renderer ports by copy number
    assign scroll_bus = {sp_scroll_y, sp_scroll_x, tx_scroll_y, tx_scroll_x,
                         fg_scroll_y, fg_scroll_x, bg_scroll_y, bg_scroll_x};
    assign copy_bus   = {spr_data, scr2_data, scr1_data, scr0_data};

    gcu_top uut (.*);

    initial begin
        CLK96 = 1'b0;
        forever #10 CLK96 = ~CLK96;
    end

    task automatic check(input string name, input logic [DATA_W-1:0] exp,
                         input logic [DATA_W-1:0] act);
        checks++;
        assert (act === exp) else begin
            errors++;
            $display("Fail %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    // one op from a falling edge until ack is back and then one idle cycle
    task automatic bus_op(input int op, input logic [DATA_W-1:0] data);
        int n;
        din = data;
        {op_select_reg, op_write_reg, op_set_ram_ptr,
         op_write_ram, op_read_ram_h, op_read_ram_l} = 6'b100000 >> op;
        n = 0;
        @(negedge CLK96);
        while (!ack && n < ACK_TIMEOUT) begin
            @(negedge CLK96);
            n++;
        end
        assert (ack) else begin
            timeouts++;
            $display("ack did not come back within %0d cycles on op %0d", ACK_TIMEOUT, op);
        end
        {op_select_reg, op_write_reg, op_set_ram_ptr,
         op_write_ram, op_read_ram_h, op_read_ram_l} = '0;
        @(negedge CLK96);
    endtask

    initial begin
        logic [DATA_W-1:0]  base, data;
        logic [DATA_W-1:0]  words [8];
        logic [VRAM_AW-1:0] copy_addr [8];
        logic [VRAM_AW-1:0] copy_base [4];
        logic [VRAM_AW-1:0] offset;
        logic [7:0]         hold_sel [3];
        logic [1:0]         layer;
        logic               set, h_win, v_win;

        void'($urandom(39942));
        {checks, errors, timeouts} = '0;
        RESET96 = 1'b1;
        {din, op_select_reg, op_write_reg, op_set_ram_ptr,
         op_write_ram, op_read_ram_h, op_read_ram_l} = '0;
        {h, v, hs_start, hs_end, vs_start, vs_end} = '0;
        {scr0_addr, scr1_addr, scr2_addr, spr_addr} = '0;
        flip_x_in = 1'b1;
        flip_y_in = 1'b0;
        repeat (3) @(posedge CLK96);
        @(negedge CLK96);
        RESET96 = 1'b0;

        // flips come out of reset as the inverse of their inputs
        model_flip_x = {4{~flip_x_in}};
        model_flip_y = {4{~flip_y_in}};
        check("ack after reset", 16'h1, 16'(ack));
        check("vint after reset", 16'h1, 16'(vint));
        check("flip_x after reset", 16'(model_flip_x), 16'(flip_x));
        check("flip_y after reset", 16'(model_flip_y), 16'(flip_y));
        for (int i = 0; i < 8; i++) begin
            model_scroll[i] = '0;
            check("scroll after reset", '0, scroll_bus[i*DATA_W +: DATA_W]);
        end

        // rounds with flip set then flip clear then a random mode
        for (int round = 0; round < 3; round++) begin
            for (int idx = 0; idx < 8; idx++) begin
                set = (round == 2) ? 1'($urandom) : (round == 0);
                data = 16'($urandom);
                layer = 2'(idx / 2);
                flip_x_in = 1'($urandom);
                flip_y_in = 1'($urandom);
                // upper byte and unused bits carry noise
                bus_op(OP_SEL, {8'($urandom), set, 3'($urandom), 4'(idx)});
                bus_op(OP_WREG, data);
                model_scroll[idx] = data;
                if (idx % 2 == 1) begin
                    model_flip_y[layer] = set ? model_flip_y[layer] | flip_y_in
                                              : model_flip_y[layer] & ~flip_y_in;
                end else begin
                    model_flip_x[layer] = set ? model_flip_x[layer] | flip_x_in
                                              : model_flip_x[layer] & ~flip_x_in;
                end
                for (int j = 0; j < 8; j++) begin
                    check($sformatf("scroll reg %0d", j), model_scroll[j],
                          scroll_bus[j*DATA_W +: DATA_W]);
                end
                check("flip_x", 16'(model_flip_x), 16'(flip_x));
                check("flip_y", 16'(model_flip_y), 16'(flip_y));
            end
        end

        // burst of writes from one pointer load and reads back at each offset
        base = 16'h0100 + 16'($urandom % 256);
        bus_op(OP_PTR, base);
        for (int k = 0; k < 8; k++) begin
            words[k] = 16'($urandom);
            bus_op(OP_WRAM, words[k]);
        end
        for (int k = 0; k < 7; k++) begin
            bus_op(OP_PTR, base + 16'(k));
            bus_op(OP_RDH, '0);
            check("read high", words[k], dout);
            bus_op(OP_RDL, '0);
            check("read low", words[k+1], dout);
            // same word again means neither read moved the pointer
            bus_op(OP_RDH, '0);
            check("read high again", words[k], dout);
        end

        // two addresses per copy at the ends of its window
        copy_addr = '{13'h0000, 13'h07FF, 13'h0800, 13'h0FFF,
                      13'h1000, 13'h17FF, 13'h1800, 13'h1BFF};
        copy_base = '{LAYER0_BASE, LAYER1_BASE, LAYER2_BASE, SPRITE_BASE};
        for (int i = 0; i < 8; i++) begin
            data = 16'($urandom);
            bus_op(OP_PTR, 16'(copy_addr[i]));
            bus_op(OP_WRAM, data);
            offset = copy_addr[i] - copy_base[i / 2];
            {scr0_addr, scr1_addr, scr2_addr} = {3{offset[LAYER_AW-1:0]}};
            spr_addr = offset[SPRITE_AW-1:0];
            @(negedge CLK96);
            check($sformatf("copy %0d offset %h", i / 2, offset), data,
                  copy_bus[(i / 2)*DATA_W +: DATA_W]);
        end

        // vint drops at the clear line and stays low until an ack register is selected
        hold_sel = '{8'h0F, 8'h8F, 8'h0E};
        for (int i = 0; i < 3; i++) begin
            bus_op(OP_SEL, 16'h0001);
            v = VINT_CLEAR_LINE;
            @(negedge CLK96);
            check("vint at clear line", 16'h0, 16'(vint));
            v = '0;
            @(negedge CLK96);
            check("vint held low", 16'h0, 16'(vint));
            bus_op(OP_SEL, 16'(hold_sel[i]));
            check($sformatf("vint after select %h", hold_sel[i]), 16'h1, 16'(vint));
        end

        // outputs trail the beam inputs by one clock across random windows
        hs_start = COORD_W'(20 + $urandom % 40);
        hs_end   = hs_start + COORD_W'(8 + $urandom % 16);
        vs_start = COORD_W'(100 + $urandom % 50);
        vs_end   = vs_start + COORD_W'(2 + $urandom % 6);
        h = '0;
        v = '0;
        h_win = 1'b0;
        v_win = 1'b0;
        for (int vv = vs_start - 2; vv <= vs_end + 2; vv++) begin
            for (int hh = hs_start - 2; hh <= hs_end + 2; hh++) begin
                @(negedge CLK96);
                check("hsync", 16'(!h_win), 16'(hsync));
                check("vsync", 16'(!v_win), 16'(vsync));
                check("fblank", 16'(!(h_win || v_win)), 16'(fblank));
                h = COORD_W'(hh);
                v = COORD_W'(vv);
                h_win = (hh > hs_start) && (hh < hs_end);
                v_win = (vv >= vs_start) && (vv <= vs_end);
            end
        end

        $display("checks %0d, wrong values %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- gcu_top.sv
// CPU-facing tilemap controller top, joining bus sequencer, pointer, registers, RAM and timing
`timescale 1ns/1ps

module gcu_top import gcu_pkg::*; (
    input  logic                 CLK96,
    input  logic                 RESET96,
    input  logic [DATA_W-1:0]    din,
    input  logic                 op_select_reg,
    input  logic                 op_write_reg,
    input  logic                 op_set_ram_ptr,
    input  logic                 op_write_ram,
    input  logic                 op_read_ram_h,
    input  logic                 op_read_ram_l,
    input  logic                 flip_x_in,
    input  logic                 flip_y_in,
    output logic [DATA_W-1:0]    dout,
    output logic                 ack,
    output logic [DATA_W-1:0]    bg_scroll_x,
    output logic [DATA_W-1:0]    bg_scroll_y,
    output logic [DATA_W-1:0]    fg_scroll_x,
    output logic [DATA_W-1:0]    fg_scroll_y,
    output logic [DATA_W-1:0]    tx_scroll_x,
    output logic [DATA_W-1:0]    tx_scroll_y,
    output logic [DATA_W-1:0]    sp_scroll_x,
    output logic [DATA_W-1:0]    sp_scroll_y,
    output logic [3:0]           flip_x,
    output logic [3:0]           flip_y,
    input  logic [COORD_W-1:0]   h,
    input  logic [COORD_W-1:0]   v,
    input  logic [COORD_W-1:0]   hs_start,
    input  logic [COORD_W-1:0]   hs_end,
    input  logic [COORD_W-1:0]   vs_start,
    input  logic [COORD_W-1:0]   vs_end,
    output logic                 hsync,
    output logic                 vsync,
    output logic                 fblank,
    output logic                 vint,
    input  logic [LAYER_AW-1:0]  scr0_addr,
    input  logic [LAYER_AW-1:0]  scr1_addr,
    input  logic [LAYER_AW-1:0]  scr2_addr,
    input  logic [SPRITE_AW-1:0] spr_addr,
    output logic [DATA_W-1:0]    scr0_data,
    output logic [DATA_W-1:0]    scr1_data,
    output logic [DATA_W-1:0]    scr2_data,
    output logic [DATA_W-1:0]    spr_data
);

    logic               ram_we;
    logic [VRAM_AW-1:0] ram_addr;
    logic [DATA_W-1:0]  ram_din;
    logic [DATA_W-1:0]  cpu_rdata;
    logic [DATA_W-1:0]  ptr;
    logic               ptr_load;
    logic               ptr_inc;
    logic               reg_sel_load;
    logic               reg_write;
    reg_select_t        reg_sel;

    gcu_bus_fsm u_bus_fsm (
        .CLK96(CLK96), .RESET96(RESET96), .din(din),
        .op_select_reg(op_select_reg), .op_write_reg(op_write_reg),
        .op_set_ram_ptr(op_set_ram_ptr), .op_write_ram(op_write_ram),
        .op_read_ram_h(op_read_ram_h), .op_read_ram_l(op_read_ram_l),
        .ptr(ptr), .cpu_rdata(cpu_rdata), .ack(ack), .dout(dout),
        .ram_we(ram_we), .ram_addr(ram_addr), .ram_din(ram_din),
        .ptr_load(ptr_load), .ptr_inc(ptr_inc),
        .reg_sel_load(reg_sel_load), .reg_write(reg_write)
    );

    gcu_ram_ptr u_ram_ptr (
        .CLK96(CLK96), .RESET96(RESET96), .din(din),
        .ptr_load(ptr_load), .ptr_inc(ptr_inc), .ptr(ptr)
    );

    gcu_scroll_regs u_scroll_regs (
        .CLK96(CLK96), .RESET96(RESET96), .din(din),
        .reg_sel_load(reg_sel_load), .reg_write(reg_write),
        .flip_x_in(flip_x_in), .flip_y_in(flip_y_in), .reg_sel(reg_sel),
        .bg_scroll_x(bg_scroll_x), .bg_scroll_y(bg_scroll_y),
        .fg_scroll_x(fg_scroll_x), .fg_scroll_y(fg_scroll_y),
        .tx_scroll_x(tx_scroll_x), .tx_scroll_y(tx_scroll_y),
        .sp_scroll_x(sp_scroll_x), .sp_scroll_y(sp_scroll_y),
        .flip_x(flip_x), .flip_y(flip_y)
    );

    gcu_vram u_vram (
        .CLK96(CLK96), .ram_we(ram_we), .ram_addr(ram_addr), .ram_din(ram_din),
        .scr0_addr(scr0_addr), .scr1_addr(scr1_addr), .scr2_addr(scr2_addr),
        .spr_addr(spr_addr), .cpu_rdata(cpu_rdata),
        .scr0_data(scr0_data), .scr1_data(scr1_data), .scr2_data(scr2_data),
        .spr_data(spr_data)
    );

    gcu_video_timing u_video_timing (
        .CLK96(CLK96), .RESET96(RESET96), .h(h), .v(v),
        .hs_start(hs_start), .hs_end(hs_end), .vs_start(vs_start), .vs_end(vs_end),
        .reg_sel(reg_sel), .hsync(hsync), .vsync(vsync), .fblank(fblank), .vint(vint)
    );

endmodule

//--- gcu_video_timing.sv
// registered sync and blank from the beam position, plus the vertical interrupt line
`timescale 1ns/1ps

module gcu_video_timing import gcu_pkg::*; (
    input  logic               CLK96,
    input  logic               RESET96,
    input  logic [COORD_W-1:0] h,
    input  logic [COORD_W-1:0] v,
    input  logic [COORD_W-1:0] hs_start,
    input  logic [COORD_W-1:0] hs_end,
    input  logic [COORD_W-1:0] vs_start,
    input  logic [COORD_W-1:0] vs_end,
    input  reg_select_t        reg_sel,
    output logic               hsync,
    output logic               vsync,
    output logic               fblank,
    output logic               vint
);

    logic h_win;
    logic v_win;
    logic vint_hold;

    // horizontal window excludes its ends, vertical includes them
    assign h_win = (h > hs_start) && (h < hs_end);
    assign v_win = (v >= vs_start) && (v <= vs_end);

    assign vint_hold = (reg_sel.raw == {4'h0, VINT_ACK_A}) ||
                       (reg_sel.raw == {4'h0, VINT_ACK_B}) ||
                       (reg_sel.raw == {4'h8, VINT_ACK_B});

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            hsync  <= 1'b1;
            vsync  <= 1'b1;
            fblank <= 1'b1;
            vint   <= 1'b1;
        end else begin
            hsync  <= ~h_win;
            vsync  <= ~v_win;
            fblank <= ~(h_win | v_win);
            // active low, falls at the clear line unless an ack register is selected
            if (vint_hold) begin
                vint <= 1'b1;
            end else if (v == VINT_CLEAR_LINE) begin
                vint <= 1'b0;
            end
        end
    end

endmodule

//--- gcu_vram.sv
// main video RAM plus the layer and sprite copies that the renderers read
`timescale 1ns/1ps

module gcu_vram import gcu_pkg::*; (
    input  logic                 CLK96,
    input  logic                 ram_we,
    input  logic [VRAM_AW-1:0]   ram_addr,
    input  logic [DATA_W-1:0]    ram_din,
    input  logic [LAYER_AW-1:0]  scr0_addr,
    input  logic [LAYER_AW-1:0]  scr1_addr,
    input  logic [LAYER_AW-1:0]  scr2_addr,
    input  logic [SPRITE_AW-1:0] spr_addr,
    output logic [DATA_W-1:0]    cpu_rdata,
    output logic [DATA_W-1:0]    scr0_data,
    output logic [DATA_W-1:0]    scr1_data,
    output logic [DATA_W-1:0]    scr2_data,
    output logic [DATA_W-1:0]    spr_data
);

    logic [DATA_W-1:0]    main_ram [2**VRAM_AW];
    logic [DATA_W-1:0]    scr_ram  [3][2**LAYER_AW];
    logic [DATA_W-1:0]    spr_ram  [2**SPRITE_AW];
    logic [2:0]           scr_we;
    logic [LAYER_AW-1:0]  scr_off  [3];
    logic [LAYER_AW-1:0]  scr_raddr [3];
    logic [DATA_W-1:0]    scr_q    [3];
    logic                 spr_we;
    logic [SPRITE_AW-1:0] spr_off;

    // each copy takes only the writes that fall in its window
    assign scr_we[0] = ram_we && ram_addr >= LAYER0_BASE && ram_addr < LAYER1_BASE;
    assign scr_we[1] = ram_we && ram_addr >= LAYER1_BASE && ram_addr < LAYER2_BASE;
    assign scr_we[2] = ram_we && ram_addr >= LAYER2_BASE && ram_addr < SPRITE_BASE;
    assign spr_we    = ram_we && ram_addr >= SPRITE_BASE && ram_addr < SPRITE_END;

    assign scr_off[0] = LAYER_AW'(ram_addr - LAYER0_BASE);
    assign scr_off[1] = LAYER_AW'(ram_addr - LAYER1_BASE);
    assign scr_off[2] = LAYER_AW'(ram_addr - LAYER2_BASE);
    assign spr_off    = SPRITE_AW'(ram_addr - SPRITE_BASE);

    assign scr_raddr[0] = scr0_addr;
    assign scr_raddr[1] = scr1_addr;
    assign scr_raddr[2] = scr2_addr;

    always_ff @(posedge CLK96) begin
        if (ram_we) begin
            main_ram[ram_addr] <= ram_din;
        end
        cpu_rdata <= main_ram[ram_addr];
    end

    always_ff @(posedge CLK96) begin
        for (int i = 0; i < 3; i++) begin
            if (scr_we[i]) begin
                scr_ram[i][scr_off[i]] <= ram_din;
            end
            scr_q[i] <= scr_ram[i][scr_raddr[i]];
        end
    end

    always_ff @(posedge CLK96) begin
        if (spr_we) begin
            spr_ram[spr_off] <= ram_din;
        end
        spr_data <= spr_ram[spr_addr];
    end

    assign scr0_data = scr_q[0];
    assign scr1_data = scr_q[1];
    assign scr2_data = scr_q[2];

endmodule

//--- gcu_scroll_regs.sv
// register select latch with the eight scroll registers and per-layer flip bits
`timescale 1ns/1ps

module gcu_scroll_regs import gcu_pkg::*; (
    input  logic              CLK96,
    input  logic              RESET96,
    input  logic [DATA_W-1:0] din,
    input  logic              reg_sel_load,
    input  logic              reg_write,
    input  logic              flip_x_in,
    input  logic              flip_y_in,
    output reg_select_t       reg_sel,
    output logic [DATA_W-1:0] bg_scroll_x,
    output logic [DATA_W-1:0] bg_scroll_y,
    output logic [DATA_W-1:0] fg_scroll_x,
    output logic [DATA_W-1:0] fg_scroll_y,
    output logic [DATA_W-1:0] tx_scroll_x,
    output logic [DATA_W-1:0] tx_scroll_y,
    output logic [DATA_W-1:0] sp_scroll_x,
    output logic [DATA_W-1:0] sp_scroll_y,
    output logic [3:0]        flip_x,
    output logic [3:0]        flip_y
);

    logic [DATA_W-1:0] scroll_q [8];
    logic [1:0]        layer;
    logic              next_flip_x;
    logic              next_flip_y;
    logic              scroll_hit;

    // index pairs map onto layers bg, fg, text, sprite
    assign layer      = reg_sel.f.idx[2:1];
    assign scroll_hit = reg_write && (reg_sel.f.idx <= REG_SP_Y);

    // set mode ORs the input in, clear mode masks it out
    assign next_flip_x = reg_sel.f.flip_set ? (flip_x[layer] | flip_x_in)
                                            : (flip_x[layer] & ~flip_x_in);
    assign next_flip_y = reg_sel.f.flip_set ? (flip_y[layer] | flip_y_in)
                                            : (flip_y[layer] & ~flip_y_in);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            reg_sel <= '0;
            flip_x  <= {4{~flip_x_in}};
            flip_y  <= {4{~flip_y_in}};
            for (int i = 0; i < 8; i++) begin
                scroll_q[i] <= '0;
            end
        end else begin
            if (reg_sel_load) begin
                reg_sel.raw <= din[7:0] & REG_SEL_MASK;
            end
            if (scroll_hit) begin
                scroll_q[reg_sel.f.idx[2:0]] <= din;
                if (reg_sel.f.idx[0]) begin
                    flip_y[layer] <= next_flip_y;
                end else begin
                    flip_x[layer] <= next_flip_x;
                end
            end
        end
    end

    assign bg_scroll_x = scroll_q[REG_BG_X[2:0]];
    assign bg_scroll_y = scroll_q[REG_BG_Y[2:0]];
    assign fg_scroll_x = scroll_q[REG_FG_X[2:0]];
    assign fg_scroll_y = scroll_q[REG_FG_Y[2:0]];
    assign tx_scroll_x = scroll_q[REG_TX_X[2:0]];
    assign tx_scroll_y = scroll_q[REG_TX_Y[2:0]];
    assign sp_scroll_x = scroll_q[REG_SP_X[2:0]];
    assign sp_scroll_y = scroll_q[REG_SP_Y[2:0]];

endmodule

//--- gcu_ram_ptr.sv
// video RAM pointer, loaded by the CPU and stepped after every RAM write
`timescale 1ns/1ps

module gcu_ram_ptr import gcu_pkg::*; (
    input  logic              CLK96,
    input  logic              RESET96,
    input  logic [DATA_W-1:0] din,
    input  logic              ptr_load,
    input  logic              ptr_inc,
    output logic [DATA_W-1:0] ptr
);

    // full 16 bits kept, only the low bits reach the RAM
    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            ptr <= '0;
        end else if (ptr_load) begin
            ptr <= din;
        end else if (ptr_inc) begin
            ptr <= ptr + 1'b1;
        end
    end

endmodule

//--- gcu_bus_fsm.sv
// sequences CPU bus operations into RAM strobes, register loads and the acknowledge
`timescale 1ns/1ps

module gcu_bus_fsm import gcu_pkg::*; (
    input  logic               CLK96,
    input  logic               RESET96,
    input  logic [DATA_W-1:0]  din,
    input  logic               op_select_reg,
    input  logic               op_write_reg,
    input  logic               op_set_ram_ptr,
    input  logic               op_write_ram,
    input  logic               op_read_ram_h,
    input  logic               op_read_ram_l,
    input  logic [DATA_W-1:0]  ptr,
    input  logic [DATA_W-1:0]  cpu_rdata,
    output logic               ack,
    output logic [DATA_W-1:0]  dout,
    output logic               ram_we,
    output logic [VRAM_AW-1:0] ram_addr,
    output logic [DATA_W-1:0]  ram_din,
    output logic               ptr_load,
    output logic               ptr_inc,
    output logic               reg_sel_load,
    output logic               reg_write
);

    logic [5:0] op_vec;
    logic [5:0] last_op;
    logic [2:0] st;
    logic [2:0] st_cur;
    logic       op_read;

    assign op_vec = {op_select_reg, op_write_reg, op_set_ram_ptr,
                     op_write_ram, op_read_ram_h, op_read_ram_l};
    assign op_read = op_read_ram_h | op_read_ram_l;

    // any new op pattern starts again from the first step
    assign st_cur = (op_vec != last_op) ? ST_IDLE : st;

    // register and pointer loads act for every cycle the op is held
    assign reg_sel_load = op_select_reg;
    assign reg_write    = op_write_reg;
    assign ptr_load     = op_set_ram_ptr;

    // pointer advances on the edge that completes the RAM write
    assign ptr_inc = ram_we;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            st      <= ST_IDLE;
            last_op <= '0;
            ack     <= 1'b1;
            ram_we  <= 1'b0;
        end else begin
            last_op <= op_vec;
            ram_we  <= 1'b0;
            if (op_write_ram) begin
                case (st_cur)
                    ST_IDLE: begin
                        ack    <= 1'b0;
                        ram_we <= 1'b1;
                        st     <= ST_WR;
                    end
                    ST_WR: begin
                        ack <= 1'b1;
                        st  <= ST_DONE;
                    end
                    default: ack <= 1'b1;
                endcase
            end else if (op_read) begin
                case (st_cur)
                    ST_IDLE: begin
                        ack <= 1'b0;
                        st  <= ST_RD_WAIT;
                    end
                    // RAM output registers during this step
                    ST_RD_WAIT: st <= ST_RD_CAP;
                    ST_RD_CAP: begin
                        ack <= 1'b1;
                        st  <= ST_DONE;
                    end
                    default: ack <= 1'b1;
                endcase
            end else begin
                ack <= 1'b1;
                st  <= ST_IDLE;
            end
        end
    end

    // address, write data and read data
    always_ff @(posedge CLK96) begin
        if (st_cur == ST_IDLE) begin
            if (op_write_ram) begin
                ram_addr <= ptr[VRAM_AW-1:0];
                ram_din  <= din;
            end else if (op_read) begin
                // low word sits one above the pointer
                ram_addr <= ptr[VRAM_AW-1:0] + VRAM_AW'(op_read_ram_l);
            end
        end
        if (op_read && st_cur == ST_RD_CAP) begin
            dout <= cpu_rdata;
        end
    end

endmodule

//--- gcu_pkg.sv
// shared widths, register map, layer copy bounds and select-word layout, imported by every block
package gcu_pkg;

    localparam int DATA_W    = 16;
    localparam int VRAM_AW   = 13;
    localparam int LAYER_AW  = 11;
    localparam int SPRITE_AW = 10;
    localparam int COORD_W   = 9;

    // main RAM ranges mirrored into the renderer copies
    localparam logic [VRAM_AW-1:0] LAYER0_BASE = 13'h0000;
    localparam logic [VRAM_AW-1:0] LAYER1_BASE = 13'h0800;
    localparam logic [VRAM_AW-1:0] LAYER2_BASE = 13'h1000;
    localparam logic [VRAM_AW-1:0] SPRITE_BASE = 13'h1800;
    localparam logic [VRAM_AW-1:0] SPRITE_END  = 13'h1C00;

    // scroll register indices, x on even and y on odd
    localparam logic [3:0] REG_BG_X = 4'd0;
    localparam logic [3:0] REG_BG_Y = 4'd1;
    localparam logic [3:0] REG_FG_X = 4'd2;
    localparam logic [3:0] REG_FG_Y = 4'd3;
    localparam logic [3:0] REG_TX_X = 4'd4;
    localparam logic [3:0] REG_TX_Y = 4'd5;
    localparam logic [3:0] REG_SP_X = 4'd6;
    localparam logic [3:0] REG_SP_Y = 4'd7;

    // selecting either of these holds the interrupt line high
    localparam logic [3:0] VINT_ACK_A = 4'hE;
    localparam logic [3:0] VINT_ACK_B = 4'hF;
    localparam logic [COORD_W-1:0] VINT_CLEAR_LINE = 9'h0E6;

    localparam logic [7:0] REG_SEL_MASK = 8'h8F;

    // bus sequencer steps
    localparam logic [2:0] ST_IDLE    = 3'd0;
    localparam logic [2:0] ST_WR      = 3'd1;
    localparam logic [2:0] ST_RD_WAIT = 3'd2;
    localparam logic [2:0] ST_RD_CAP  = 3'd3;
    localparam logic [2:0] ST_DONE    = 3'd4;

    // select word, read as a raw byte or as flip mode plus index
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic       flip_set;
            logic [2:0] unused;
            logic [3:0] idx;
        } f;
    } reg_select_t;

endpackage
